/* sources.f */
cpu_pkg.sv
opcode_pkg.sv
insn_decode.sv
alu_execute.sv
reg_writeback.sv
cpu6809_core.sv
cpu6809_checker.sv
tb_cpu6809.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu6809
SEED ?= 33
FLIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP SEED FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_cpu6809.sv */
module tb_cpu6809;
	import cpu_pkg::*;

	parameter int SEED = 33;

	localparam int PERIOD = 40;
	localparam int N_IMM = 300;
	localparam int N_INH = 300;
	localparam int N_BR = 100;
	localparam int N_BURST = 64;
	localparam int N_UNK = 60;
	localparam int N_TOTAL = N_IMM + N_INH + 3 * N_BR + N_BURST + N_UNK;	// Instructions issued
	localparam logic [3:0] IMM_LO [10] =
		'{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'ha, 4'hb};
	localparam logic [3:0] INH_LO [11] =
		'{4'h0, 4'h3, 4'h4, 4'h6, 4'h7, 4'h8, 4'h9, 4'ha, 4'hc, 4'hd, 4'hf};

	logic clk;
	logic rst;
	logic insn_valid_i;
	logic [7:0] opcode_i;
	logic [7:0] operand_i;
	logic [7:0] acca_o;
	logic [7:0] accb_o;
	logic [7:0] cc_o;
	logic [15:0] pc_o;
	logic done_o;

	integer seed;
	int errors;
	int test_errors;
	int checks;
	string test_name;
	logic [7:0] ma;	// Model registers
	logic [7:0] mb;
	logic [7:0] mcc;
	logic [15:0] mpc;
	logic [39:0] exp_q [$];
	logic [1:0] strobe_hist;

	cpu6809_core uut (
		.clk(clk), .rst(rst),
		.insn_valid_i(insn_valid_i), .opcode_i(opcode_i), .operand_i(operand_i),
		.acca_o(acca_o), .accb_o(accb_o), .cc_o(cc_o), .pc_o(pc_o), .done_o(done_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#((N_TOTAL * 3 + 20) * PERIOD);
		$display("Timeout: the run did not finish within the expected time");
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [7:0] rnd8();
		logic [31:0] rv;
		rv = $random(seed);
		return rv[7:0];
	endfunction

	function automatic logic is_kept(input logic [7:0] op);
		logic hit;
		hit = (op[7:4] == 4'h2) || (op == 8'h12) || (op == 8'h1a) || (op == 8'h1c);
		for (int i = 0; i < 11; i++)
			if ((op[7:4] == 4'h4 || op[7:4] == 4'h5) && op[3:0] == INH_LO[i])
				hit = 1'b1;
		for (int i = 0; i < 10; i++)
			if ((op[7:4] == 4'h8 || op[7:4] == 4'hc) && op[3:0] == IMM_LO[i])
				hit = 1'b1;
		return hit;
	endfunction

	task automatic note_failure(input string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	// Reference model, applied when an instruction is issued
	task automatic model_step(input logic [7:0] op, input logic [7:0] opr);
		logic [7:0] a;
		logic [7:0] r;
		logic [8:0] w;
		logic [4:0] hs;
		logic h, n, z, v, c, cin, set_nz, wr, take;
		logic [3:0] lo;
		logic [15:0] len;
		lo = op[3:0];
		a = (op[7] ? op[6] : op[4]) ? mb : ma;
		{h, n, z, v, c} = {mcc[5], mcc[3:0]};
		set_nz = 1'b0;
		wr = 1'b0;
		take = 1'b0;
		len = 16'd1;
		r = a;
		if (is_kept(op) && op[7:5] == 3'b010)
		begin
			set_nz = 1'b1;
			wr = (lo != 4'hd);
			case (lo)
				4'h0:
				begin
					r = 8'd0 - a;
					c = (a != 8'd0);
					v = (a == 8'h80);
				end
				4'h3:
				begin
					r = ~a;
					c = 1'b1;
					v = 1'b0;
				end
				4'h4:
				begin
					r = a >> 1;
					c = a[0];
				end
				4'h6:
				begin
					r = {c, a[7:1]};
					c = a[0];
				end
				4'h7:
				begin
					r = {a[7], a[7:1]};
					c = a[0];
				end
				4'h8:
				begin
					r = {a[6:0], 1'b0};
					c = a[7];
					v = a[6] ^ a[7];
				end
				4'h9:
				begin
					r = {a[6:0], c};
					c = a[7];
					v = a[6] ^ a[7];
				end
				4'ha:
				begin
					r = a - 8'd1;
					v = (a == 8'h80);
				end
				4'hc:
				begin
					r = a + 8'd1;
					v = (a == 8'h7f);
				end
				4'hd: v = 1'b0;
				default:	// CLR
				begin
					r = 8'd0;
					v = 1'b0;
					c = 1'b0;
				end
			endcase
		end
		else if (is_kept(op) && op[7] && op[5:4] == 2'b00)
		begin
			set_nz = 1'b1;
			len = 16'd2;
			wr = (lo != 4'h1) && (lo != 4'h5);
			cin = c & (lo == 4'h2 || lo == 4'h9);
			v = 1'b0;
			case (lo)
				4'h0, 4'h1, 4'h2:
				begin
					w = {1'b0, a} - {1'b0, opr} - {8'd0, cin};
					r = w[7:0];
					v = (a[7] != opr[7]) && (r[7] != a[7]);
					c = w[8];
				end
				4'h4, 4'h5: r = a & opr;
				4'h6: r = opr;
				4'h8: r = a ^ opr;
				4'ha: r = a | opr;
				default:
				begin
					w = {1'b0, a} + {1'b0, opr} + {8'd0, cin};
					hs = {1'b0, a[3:0]} + {1'b0, opr[3:0]} + {4'd0, cin};
					r = w[7:0];
					h = hs[4];
					v = (a[7] == opr[7]) && (r[7] != a[7]);
					c = w[8];
				end
			endcase
		end
		else if (op[7:4] == 4'h2)
		begin
			len = 16'd2;
			case (lo)
				4'h0: take = 1'b1;
				4'h1: take = 1'b0;
				4'h2: take = !c && !z;
				4'h3: take = c || z;
				4'h4: take = !c;
				4'h5: take = c;
				4'h6: take = !z;
				4'h7: take = z;
				4'h8: take = !v;
				4'h9: take = v;
				4'ha: take = !n;
				4'hb: take = n;
				4'hc: take = (n == v);
				4'hd: take = (n != v);
				4'he: take = !z && (n == v);
				default: take = z || (n != v);
			endcase
		end
		else if (op == 8'h1a || op == 8'h1c)
			len = 16'd2;
		if (set_nz)
		begin
			n = r[7];
			z = (r == 8'd0);
		end
		if (wr && (op[7] ? op[6] : op[4]))
			mb = r;
		else if (wr)
			ma = r;
		if (op == 8'h1a)
			mcc = mcc | opr;
		else if (op == 8'h1c)
			mcc = mcc & opr;
		else
			mcc = {mcc[7:6], h, mcc[4], n, z, v, c};
		mpc = mpc + len + (take ? {{8{opr[7]}}, opr} : 16'd0);
	endtask

	task automatic issue(input logic [7:0] op, input logic [7:0] opr);
		@(posedge clk);
		insn_valid_i <= 1'b1;
		opcode_i <= op;
		operand_i <= opr;
		model_step(op, opr);
		exp_q.push_back({ma, mb, mcc, mpc});
	endtask

	task automatic idle();
		@(posedge clk);
		insn_valid_i <= 1'b0;
		opcode_i <= rnd8();	// Junk while no strobe
	endtask

	task automatic issue_gap(input logic [7:0] op, input logic [7:0] opr);
		logic [7:0] r;
		issue(op, opr);
		r = rnd8();
		if (r[0])
			idle();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		idle();
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
		$display("test %s: %0d errors", test_name, test_errors);
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin : monitor
		logic [39:0] exp;
		if (!rst)
		begin
			if (done_o !== strobe_hist[1])
				note_failure($sformatf("done_o in %s did not follow a strobe two cycles later",
					test_name));
			if (done_o && exp_q.size() == 0)
				note_failure("done_o rose with no instruction outstanding");
			else if (done_o)
			begin
				exp = exp_q.pop_front();
				checks++;
				if ({acca_o, accb_o, cc_o, pc_o} !== exp)
				begin
					errors++;
					test_errors++;
					$display("ERROR %s expected %h actual %h", test_name, exp,
						{acca_o, accb_o, cc_o, pc_o});
				end
			end
		end
		strobe_hist = {strobe_hist[0], insn_valid_i};
	end

	initial
	begin
		logic [7:0] op;
		logic [7:0] r;
		seed = SEED;
		rst = 1'b1;
		insn_valid_i = 1'b0;
		opcode_i = 8'd0;
		operand_i = 8'd0;
		{ma, mb, mcc, mpc} = {8'd0, 8'd0, RESET_CC, RESET_PC};
		strobe_hist = 2'b00;
		errors = 0;
		checks = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		begin_test("reset");
		repeat (4)
		begin
			@(negedge clk);
			checks++;
			if ({acca_o, accb_o, cc_o, pc_o} !== {16'd0, RESET_CC, RESET_PC})
			begin
				errors++;
				test_errors++;
				$display("ERROR %s expected %h actual %h", test_name,
					{16'd0, RESET_CC, RESET_PC}, {acca_o, accb_o, cc_o, pc_o});
			end
			if (done_o !== 1'b0)
				note_failure("done_o went high after reset with no strobe");
		end
		end_test();

		begin_test("immediate");
		for (int i = 0; i < N_IMM; i++)
		begin
			r = rnd8();
			op = {1'b1, r[7], 2'b00, IMM_LO[r[6:0] % 10]};	// 8x or Cx
			issue_gap(op, rnd8());
		end
		end_test();

		begin_test("inherent");
		for (int i = 0; i < N_INH; i++)
		begin
			r = rnd8();
			if (r[1:0] == 2'b00)	// Load, often a boundary value
				issue_gap(r[7] ? 8'hc6 : 8'h86, r[6] ? {r[5], {7{~r[5]}}} : rnd8());
			else
				issue_gap({3'b010, r[7], INH_LO[r[6:2] % 11]}, rnd8());
		end
		end_test();

		begin_test("branch");
		for (int i = 0; i < N_BR; i++)
		begin
			issue_gap(8'h1a, rnd8());
			issue_gap(8'h1c, rnd8());
			r = rnd8();
			issue_gap({4'h2, r[3:0]}, rnd8());
		end
		end_test();

		begin_test("burst");
		for (int i = 0; i < N_BURST; i++)
		begin
			r = rnd8();
			if (r[2:0] == 3'd0)
				issue(8'h86, rnd8());
			else
				issue(r[7] ? {4'h8, IMM_LO[r[6:3] % 10]} : {4'h4, INH_LO[r[6:3] % 11]}, rnd8());
		end
		end_test();

		begin_test("unknown");
		for (int i = 0; i < N_UNK; i++)
		begin
			op = rnd8();
			while (is_kept(op))
				op = rnd8();
			issue_gap(op, rnd8());
		end
		end_test();

		$display("tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* cpu6809_checker.sv */
module cpu6809_checker (
	input  logic        clk,
	input  logic        rst,
	input  logic        insn_valid_i,
	input  logic [15:0] pc_o,
	input  logic        done_o
);

	// Fixed two-cycle latency, in both directions
	done_follows_strobe: assert property (@(posedge clk) disable iff (rst)
		insn_valid_i |-> ##2 done_o)
		else $error("done_o missing two cycles after a strobe");

	done_has_strobe: assert property (@(posedge clk) disable iff (rst)
		done_o |-> $past(insn_valid_i, 2))
		else $error("done_o without a strobe two cycles earlier");

	quiet_after_reset: assert property (@(posedge clk)
		rst |=> !done_o ##1 !done_o)
		else $error("done_o high during or right after reset");

	pc_moves_on_done: assert property (@(posedge clk) disable iff (rst)
		$changed(pc_o) |-> done_o)
		else $error("pc_o changed without done_o");

endmodule

bind cpu6809_core cpu6809_checker u_checker (
	.clk(clk),
	.rst(rst),
	.insn_valid_i(insn_valid_i),
	.pc_o(pc_o),
	.done_o(done_o)
);

/* cpu6809_core.sv */
module cpu6809_core (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        insn_valid_i,
	input  logic [cpu_pkg::DATA_W-1:0]  opcode_i,
	input  logic [cpu_pkg::DATA_W-1:0]  operand_i,
	output logic [cpu_pkg::DATA_W-1:0]  acca_o,
	output logic [cpu_pkg::DATA_W-1:0]  accb_o,
	output logic [7:0]                  cc_o,
	output logic [cpu_pkg::ADDR_W-1:0]  pc_o,
	output logic                        done_o
);
	import cpu_pkg::*;
	import opcode_pkg::*;

	logic dec_valid;
	op_class_t dec_class;
	logic dec_acc_b;
	logic [DATA_W-1:0] dec_operand;
	cond_t dec_cond;
	logic [1:0] dec_len;

	logic ex_valid;
	logic ex_wr_acc;
	logic ex_acc_b;
	logic [DATA_W-1:0] ex_value;
	cc_t ex_cc;
	logic [ADDR_W-1:0] ex_pc;

	cc_t cc_q;	// Committed CC, fed back to execute

	assign cc_o = cc_q.raw;

	insn_decode u_decode (
		.clk(clk), .rst(rst),
		.insn_valid_i(insn_valid_i), .opcode_i(opcode_i), .operand_i(operand_i),
		.valid_o(dec_valid), .class_o(dec_class), .acc_b_o(dec_acc_b),
		.operand_o(dec_operand), .cond_o(dec_cond), .len_o(dec_len)
	);

	alu_execute u_execute (
		.valid_i(dec_valid), .class_i(dec_class), .acc_b_i(dec_acc_b),
		.operand_i(dec_operand), .cond_i(dec_cond), .len_i(dec_len),
		.acca_i(acca_o), .accb_i(accb_o), .cc_i(cc_q), .pc_i(pc_o),
		.valid_o(ex_valid), .wr_acc_o(ex_wr_acc), .acc_b_o(ex_acc_b),
		.value_o(ex_value), .cc_o(ex_cc), .pc_o(ex_pc)
	);

	reg_writeback u_writeback (
		.clk(clk), .rst(rst),
		.valid_i(ex_valid), .wr_acc_i(ex_wr_acc), .acc_b_i(ex_acc_b),
		.value_i(ex_value), .cc_i(ex_cc), .pc_i(ex_pc),
		.acca_o(acca_o), .accb_o(accb_o), .cc_o(cc_q), .pc_o(pc_o),
		.done_o(done_o)
	);

endmodule

/* reg_writeback.sv */
module reg_writeback (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        valid_i,
	input  logic                        wr_acc_i,
	input  logic                        acc_b_i,
	input  logic [cpu_pkg::DATA_W-1:0]  value_i,
	input  cpu_pkg::cc_t                cc_i,
	input  logic [cpu_pkg::ADDR_W-1:0]  pc_i,
	output logic [cpu_pkg::DATA_W-1:0]  acca_o,
	output logic [cpu_pkg::DATA_W-1:0]  accb_o,
	output cpu_pkg::cc_t                cc_o,
	output logic [cpu_pkg::ADDR_W-1:0]  pc_o,
	output logic                        done_o
);
	import cpu_pkg::*;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acca_o <= '0;
			accb_o <= '0;
			cc_o.raw <= RESET_CC;
			pc_o <= RESET_PC;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= valid_i;	// One pulse per retired instruction
			if (valid_i)
			begin
				cc_o <= cc_i;
				pc_o <= pc_i;
				if (wr_acc_i && !acc_b_i)
					acca_o <= value_i;
				if (wr_acc_i && acc_b_i)
					accb_o <= value_i;
			end
		end
	end

endmodule

/* alu_execute.sv */
module alu_execute (
	input  logic                        valid_i,
	input  opcode_pkg::op_class_t       class_i,
	input  logic                        acc_b_i,
	input  logic [cpu_pkg::DATA_W-1:0]  operand_i,
	input  opcode_pkg::cond_t           cond_i,
	input  logic [1:0]                  len_i,
	input  logic [cpu_pkg::DATA_W-1:0]  acca_i,
	input  logic [cpu_pkg::DATA_W-1:0]  accb_i,
	input  cpu_pkg::cc_t                cc_i,
	input  logic [cpu_pkg::ADDR_W-1:0]  pc_i,
	output logic                        valid_o,
	output logic                        wr_acc_o,
	output logic                        acc_b_o,
	output logic [cpu_pkg::DATA_W-1:0]  value_o,
	output cpu_pkg::cc_t                cc_o,
	output logic [cpu_pkg::ADDR_W-1:0]  pc_o
);
	import cpu_pkg::*;
	import opcode_pkg::*;

	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] lhs;
	logic [DATA_W-1:0] rhs;
	logic borrow_in;
	logic carry_in;
	logic [DATA_W:0] diff;
	logic [DATA_W:0] sum;
	logic [DATA_W:0] res;
	logic [ADDR_W-1:0] offset;
	logic base_cond;
	logic taken;
	cc_t cc_n;

	assign a = acc_b_i ? accb_i : acca_i;

	// NEG runs through the subtractor as 0 - a
	assign lhs = (class_i == CL_NEG) ? '0 : a;
	assign rhs = (class_i == CL_NEG) ? a : operand_i;
	assign borrow_in = (class_i == CL_SBC) & cc_i.flags.c;
	assign carry_in = (class_i == CL_ADC) & cc_i.flags.c;
	assign diff = {1'b0, lhs} - {1'b0, rhs} - (DATA_W+1)'(borrow_in);
	assign sum = {1'b0, a} + {1'b0, operand_i} + (DATA_W+1)'(carry_in);

	always_comb
	begin
		case (class_i)
			CL_NEG, CL_SUB, CL_CMP, CL_SBC:	res = diff;
			CL_ADD, CL_ADC:	res = sum;
			CL_COM:	res = {1'b1, ~a};	// C always set
			CL_LSR:	res = {a[0], 1'b0, a[7:1]};
			CL_ROR:	res = {a[0], cc_i.flags.c, a[7:1]};
			CL_ASR:	res = {a[0], a[7], a[7:1]};
			CL_ASL:	res = {a, 1'b0};
			CL_ROL:	res = {a, cc_i.flags.c};
			CL_DEC:	res = {1'b0, a - 8'd1};
			CL_INC:	res = {1'b0, a + 8'd1};
			CL_AND, CL_BIT:	res = {1'b0, a & operand_i};
			CL_LD:	res = {1'b0, operand_i};
			CL_EOR:	res = {1'b0, a ^ operand_i};
			CL_OR:	res = {1'b0, a | operand_i};
			CL_CLR:	res = '0;
			default:	res = {1'b0, a};	// TST and the non-ALU classes
		endcase
	end

	always_comb
	begin
		cc_n = cc_i;
		if (class_i inside {[CL_NEG:CL_ADD]})
		begin
			cc_n.flags.n = res[7];
			cc_n.flags.z = (res[7:0] == '0);
		end
		case (class_i)
			CL_NEG, CL_SUB, CL_CMP, CL_SBC:
			begin
				cc_n.flags.v = (lhs[7] ^ rhs[7]) & (lhs[7] ^ res[7]);
				cc_n.flags.c = res[8];	// Borrow
			end
			CL_ADD, CL_ADC:
			begin
				cc_n.flags.h = a[4] ^ operand_i[4] ^ res[4];	// Carry into bit 4
				cc_n.flags.v = ~(a[7] ^ operand_i[7]) & (a[7] ^ res[7]);
				cc_n.flags.c = res[8];
			end
			CL_COM, CL_CLR:
			begin
				cc_n.flags.v = 1'b0;
				cc_n.flags.c = res[8];
			end
			CL_LSR, CL_ROR, CL_ASR:	cc_n.flags.c = res[8];
			CL_ASL, CL_ROL:
			begin
				cc_n.flags.v = res[7] ^ res[8];
				cc_n.flags.c = res[8];
			end
			CL_DEC:	cc_n.flags.v = (a == 8'h80);
			CL_INC:	cc_n.flags.v = (a == 8'h7f);
			CL_TST, CL_AND, CL_BIT, CL_LD, CL_EOR, CL_OR:	cc_n.flags.v = 1'b0;
			CL_ORCC:	cc_n.raw = cc_i.raw | operand_i;
			CL_ANDCC:	cc_n.raw = cc_i.raw & operand_i;
			default:	;
		endcase
	end

	// Odd condition codes invert their even partner
	always_comb
	begin
		case (cond_i[3:1])
			3'd0:	base_cond = 1'b1;	// BRA
			3'd1:	base_cond = ~(cc_i.flags.c | cc_i.flags.z);	// BHI
			3'd2:	base_cond = ~cc_i.flags.c;	// BHS
			3'd3:	base_cond = ~cc_i.flags.z;	// BNE
			3'd4:	base_cond = ~cc_i.flags.v;	// BVC
			3'd5:	base_cond = ~cc_i.flags.n;	// BPL
			3'd6:	base_cond = ~(cc_i.flags.n ^ cc_i.flags.v);	// BGE
			default:	base_cond = ~((cc_i.flags.n ^ cc_i.flags.v) | cc_i.flags.z);	// BGT
		endcase
	end

	assign taken = (class_i == CL_BRANCH) & (base_cond ^ cond_i[0]);
	assign offset = {{(ADDR_W-DATA_W){operand_i[7]}}, operand_i};

	assign valid_o = valid_i;
	assign wr_acc_o = (class_i inside {[CL_NEG:CL_ADD]}) &&
		!(class_i inside {CL_TST, CL_CMP, CL_BIT});
	assign acc_b_o = acc_b_i;
	assign value_o = res[DATA_W-1:0];
	assign cc_o = cc_n;
	assign pc_o = pc_i + ADDR_W'(len_i) + (taken ? offset : '0);	// Branches have len 2

endmodule

/* insn_decode.sv */
module insn_decode (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        insn_valid_i,
	input  logic [cpu_pkg::DATA_W-1:0]  opcode_i,
	input  logic [cpu_pkg::DATA_W-1:0]  operand_i,
	output logic                        valid_o,
	output opcode_pkg::op_class_t       class_o,
	output logic                        acc_b_o,
	output logic [cpu_pkg::DATA_W-1:0]  operand_o,
	output opcode_pkg::cond_t           cond_o,
	output logic [1:0]                  len_o
);
	import opcode_pkg::*;

	op_class_t cls;

	always_comb
	begin
		case (opcode_i)
			OP_NEGA, OP_NEGB:	cls = CL_NEG;
			OP_COMA, OP_COMB:	cls = CL_COM;
			OP_LSRA, OP_LSRB:	cls = CL_LSR;
			OP_RORA, OP_RORB:	cls = CL_ROR;
			OP_ASRA, OP_ASRB:	cls = CL_ASR;
			OP_ASLA, OP_ASLB:	cls = CL_ASL;
			OP_ROLA, OP_ROLB:	cls = CL_ROL;
			OP_DECA, OP_DECB:	cls = CL_DEC;
			OP_INCA, OP_INCB:	cls = CL_INC;
			OP_TSTA, OP_TSTB:	cls = CL_TST;
			OP_CLRA, OP_CLRB:	cls = CL_CLR;
			OP_SUBA_IMM, OP_SUBB_IMM:	cls = CL_SUB;
			OP_CMPA_IMM, OP_CMPB_IMM:	cls = CL_CMP;
			OP_SBCA_IMM, OP_SBCB_IMM:	cls = CL_SBC;
			OP_ANDA_IMM, OP_ANDB_IMM:	cls = CL_AND;
			OP_BITA_IMM, OP_BITB_IMM:	cls = CL_BIT;
			OP_LDA_IMM, OP_LDB_IMM:	cls = CL_LD;
			OP_EORA_IMM, OP_EORB_IMM:	cls = CL_EOR;
			OP_ADCA_IMM, OP_ADCB_IMM:	cls = CL_ADC;
			OP_ORA_IMM, OP_ORB_IMM:	cls = CL_OR;
			OP_ADDA_IMM, OP_ADDB_IMM:	cls = CL_ADD;
			OP_ORCC:	cls = CL_ORCC;
			OP_ANDCC:	cls = CL_ANDCC;
			OP_BRA, OP_BRN, OP_BHI, OP_BLS, OP_BHS, OP_BLO, OP_BNE, OP_BEQ,
			OP_BVC, OP_BVS, OP_BPL, OP_BMI, OP_BGE, OP_BLT, OP_BGT, OP_BLE:
				cls = CL_BRANCH;
			OP_NOP:	cls = CL_NOP;
			default:	cls = CL_NOP;	// Unused opcodes retire as NOP
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_o <= 1'b0;
		else
			valid_o <= insn_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (insn_valid_i)
		begin
			class_o <= cls;
			// B lives in 5x for inherent and Cx for immediate
			acc_b_o <= opcode_i[7] ? opcode_i[6] : opcode_i[4];
			operand_o <= operand_i;
			cond_o <= opcode_i[3:0];
			len_o <= (cls inside {[CL_SUB:CL_BRANCH]}) ? 2'd2 : 2'd1;
		end
	end

endmodule

/* opcode_pkg.sv */
package opcode_pkg;

	// Inherent, A in 4x and B in 5x
	localparam logic [7:0] OP_NEGA = 8'h40, OP_NEGB = 8'h50;
	localparam logic [7:0] OP_COMA = 8'h43, OP_COMB = 8'h53;
	localparam logic [7:0] OP_LSRA = 8'h44, OP_LSRB = 8'h54;
	localparam logic [7:0] OP_RORA = 8'h46, OP_RORB = 8'h56;
	localparam logic [7:0] OP_ASRA = 8'h47, OP_ASRB = 8'h57;
	localparam logic [7:0] OP_ASLA = 8'h48, OP_ASLB = 8'h58;
	localparam logic [7:0] OP_ROLA = 8'h49, OP_ROLB = 8'h59;
	localparam logic [7:0] OP_DECA = 8'h4a, OP_DECB = 8'h5a;
	localparam logic [7:0] OP_INCA = 8'h4c, OP_INCB = 8'h5c;
	localparam logic [7:0] OP_TSTA = 8'h4d, OP_TSTB = 8'h5d;
	localparam logic [7:0] OP_CLRA = 8'h4f, OP_CLRB = 8'h5f;

	// Immediate, A in 8x and B in Cx
	localparam logic [7:0] OP_SUBA_IMM = 8'h80, OP_SUBB_IMM = 8'hc0;
	localparam logic [7:0] OP_CMPA_IMM = 8'h81, OP_CMPB_IMM = 8'hc1;
	localparam logic [7:0] OP_SBCA_IMM = 8'h82, OP_SBCB_IMM = 8'hc2;
	localparam logic [7:0] OP_ANDA_IMM = 8'h84, OP_ANDB_IMM = 8'hc4;
	localparam logic [7:0] OP_BITA_IMM = 8'h85, OP_BITB_IMM = 8'hc5;
	localparam logic [7:0] OP_LDA_IMM = 8'h86, OP_LDB_IMM = 8'hc6;
	localparam logic [7:0] OP_EORA_IMM = 8'h88, OP_EORB_IMM = 8'hc8;
	localparam logic [7:0] OP_ADCA_IMM = 8'h89, OP_ADCB_IMM = 8'hc9;
	localparam logic [7:0] OP_ORA_IMM = 8'h8a, OP_ORB_IMM = 8'hca;
	localparam logic [7:0] OP_ADDA_IMM = 8'h8b, OP_ADDB_IMM = 8'hcb;

	// Short branches, each pair is a condition and its inverse
	localparam logic [7:0] OP_BRA = 8'h20, OP_BRN = 8'h21;
	localparam logic [7:0] OP_BHI = 8'h22, OP_BLS = 8'h23;
	localparam logic [7:0] OP_BHS = 8'h24, OP_BLO = 8'h25;
	localparam logic [7:0] OP_BNE = 8'h26, OP_BEQ = 8'h27;
	localparam logic [7:0] OP_BVC = 8'h28, OP_BVS = 8'h29;
	localparam logic [7:0] OP_BPL = 8'h2a, OP_BMI = 8'h2b;
	localparam logic [7:0] OP_BGE = 8'h2c, OP_BLT = 8'h2d;
	localparam logic [7:0] OP_BGT = 8'h2e, OP_BLE = 8'h2f;

	localparam logic [7:0] OP_NOP = 8'h12;
	localparam logic [7:0] OP_ORCC = 8'h1a;
	localparam logic [7:0] OP_ANDCC = 8'h1c;

	// Order is relied on, ALU classes run from CL_NEG to CL_ADD
	typedef enum logic [4:0]
	{
		CL_NOP,
		CL_NEG, CL_COM, CL_LSR, CL_ROR, CL_ASR, CL_ASL, CL_ROL,
		CL_DEC, CL_INC, CL_TST, CL_CLR,
		CL_SUB, CL_CMP, CL_SBC, CL_AND, CL_BIT, CL_LD,
		CL_EOR, CL_ADC, CL_OR, CL_ADD,
		CL_ORCC, CL_ANDCC,
		CL_BRANCH
	} op_class_t;

	typedef logic [3:0] cond_t;

endpackage

/* cpu_pkg.sv */
package cpu_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	localparam logic [ADDR_W-1:0] RESET_PC = '0;

	// Mask bits inside the CC byte
	localparam int FLAG_F = 6;
	localparam int FLAG_I = 4;

	localparam logic [7:0] RESET_CC = 8'((1 << FLAG_F) | (1 << FLAG_I));	// Interrupts masked

	typedef union packed
	{
		logic [7:0] raw;
		struct packed
		{
			logic e;
			logic f;
			logic h;
			logic i;
			logic n;
			logic z;
			logic v;
			logic c;
		} flags;
	} cc_t;

endpackage
